// ==== Makefile ====
# Verilator build and run for the MAC unit testbench

VERILATOR ?= verilator
TOP ?= mac_unit_tb
FILELIST ?= mac_unit.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(wildcard src/*.sv) $(wildcard tb/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mac_unit.f ====
src/mac_pkg.sv
src/credit_fifo.sv
src/mac_decode.sv
src/mac_execute.sv
src/mac_result.sv
src/mac_unit.sv
tb/mac_unit_tb.sv

// ==== src/credit_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
	parameter type T = logic,
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic multAddRst,
	input logic push,
	input T push_data,
	input logic pop,
	output T pop_data,
	output logic empty,
	output logic full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Entry storage
	T mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	// Head entry always visible
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap at DEPTH, not at a power of two
	always_ff @(posedge clk or posedge multAddRst) begin
		if (multAddRst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Count only moves on a lone push or pop
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Credit discipline upstream keeps these quiet
	a_no_overflow: assert property (@(posedge clk) disable iff (multAddRst) full |-> !push)
		else $error("credit_fifo push while full");
	a_no_underflow: assert property (@(posedge clk) disable iff (multAddRst) empty |-> !pop)
		else $error("credit_fifo pop while empty");

endmodule

`default_nettype wire

// ==== src/mac_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_decode (
	input logic clk,
	input logic multAddRst,
	input logic cmd_valid,
	input mac_pkg::mac_cmd_t cmd,
	output logic cmd_credit,
	input logic slot_free,
	output logic uop_valid,
	output mac_pkg::mac_uop_t uop
);

	import mac_pkg::*;

	mac_cmd_t head;
	logic cmd_empty;
	logic issue;
	mac_uop_t dec;

	// Free result slots downstream
	logic [ISSUE_CNT_W-1:0] issue_cnt;

	////////////////////////////////////////
	// Command buffer
	////////////////////////////////////////

	credit_fifo #(
		.T(mac_cmd_t),
		.DEPTH(CMD_DEPTH)
	) i_cmd_fifo (
		.clk(clk),
		.multAddRst(multAddRst),
		.push(cmd_valid),
		.push_data(cmd),
		.pop(issue),
		.pop_data(head),
		.empty(cmd_empty),
		.full()
	);

	// Issue only with a slot reserved in the result FIFO
	assign issue = !cmd_empty && (issue_cnt != '0);

	////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////

	always_comb begin
		dec = '0;
		dec.tag = head.tag;
		dec.data = head.data;
		dec.weight = head.weight;
		dec.sum = head.sum;
		case (head.op)
			// Plain external sum
			OP_MAC_EXT: dec.zero_prod = 1'b0;
			OP_MAC_ACC: begin
				dec.use_acc = 1'b1;
				dec.acc_wr = 1'b1;
			end
			// Sum passes straight into the accumulator
			OP_ACC_LOAD: begin
				dec.zero_prod = 1'b1;
				dec.acc_wr = 1'b1;
			end
			// Reserved, zero product plus zero sum gives value 0
			default: begin
				dec.zero_prod = 1'b1;
				dec.sum = '0;
				dec.err = 1'b1;
			end
		endcase
	end

	// Payload
	always_ff @(posedge clk) begin
		if (issue) begin
			uop <= dec;
		end
	end

	always_ff @(posedge clk or posedge multAddRst) begin
		if (multAddRst) begin
			uop_valid <= 1'b0;
			cmd_credit <= 1'b0;
			issue_cnt <= ISSUE_CNT_W'(RES_BUF_DEPTH);
		end else begin
			uop_valid <= issue;
			// Freed FIFO entry goes back to the sender
			cmd_credit <= issue;
			if (issue && !slot_free) begin
				issue_cnt <= issue_cnt - 1'b1;
			end else if (slot_free && !issue) begin
				issue_cnt <= issue_cnt + 1'b1;
			end
		end
	end

	// Result side never returns more slots than exist
	a_issue_cnt_max: assert property (@(posedge clk) disable iff (multAddRst)
		issue_cnt <= ISSUE_CNT_W'(RES_BUF_DEPTH))
		else $error("issue credit count above result FIFO depth");

endmodule

`default_nettype wire

// ==== src/mac_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_execute (
	input logic clk,
	input logic multAddRst,
	input logic uop_valid,
	input mac_pkg::mac_uop_t uop,
	output logic exe_valid,
	output mac_pkg::mac_res_t exe_res
);

	import mac_pkg::*;

	// Stage 1 operands
	logic s1_valid;
	mac_uop_t s1_uop;

	// Stage 2 product plus the rest of the op
	logic s2_valid;
	mac_uop_t s2_uop;
	logic signed [PROD_W-1:0] s2_prod;

	logic signed [2*DATA_W-1:0] full_prod;
	logic signed [DATA_W-1:0] sum_sel;
	logic signed [TOTAL_W-1:0] total;
	logic signed [DATA_W-1:0] sat_val;

	// Single accumulator
	logic signed [DATA_W-1:0] acc;

	////////////////////////////////////////
	// Stage 1 and 2
	////////////////////////////////////////

	// Dropping the low FRAC_W bits is an arithmetic shift, floor rounding
	assign full_prod = s1_uop.data * s1_uop.weight;

	always_ff @(posedge clk) begin
		s1_uop <= uop;
		s2_uop <= s1_uop;
		if (s1_uop.zero_prod) begin
			s2_prod <= '0;
		end else begin
			s2_prod <= full_prod[2*DATA_W-1:FRAC_W];
		end
	end

	////////////////////////////////////////
	// Stage 3
	////////////////////////////////////////

	always_comb begin
		// Accumulator read here, so chained ops see the latest write
		sum_sel = s2_uop.use_acc ? acc : s2_uop.sum;
		total = TOTAL_W'(s2_prod) + TOTAL_W'(sum_sel);
		// Clamp to signed Q8.8 range
		if (total > DATA_MAX) begin
			sat_val = DATA_W'(DATA_MAX);
		end else if (total < DATA_MIN) begin
			sat_val = DATA_W'(DATA_MIN);
		end else begin
			sat_val = total[DATA_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		exe_res.tag <= s2_uop.tag;
		exe_res.value <= sat_val;
		exe_res.err <= s2_uop.err;
	end

	////////////////////////////////////////
	// Valids and accumulator
	////////////////////////////////////////

	always_ff @(posedge clk or posedge multAddRst) begin
		if (multAddRst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			exe_valid <= 1'b0;
			acc <= '0;
		end else begin
			s1_valid <= uop_valid;
			s2_valid <= s1_valid;
			exe_valid <= s2_valid;
			// Load and MAC_ACC write back, reserved leaves it alone
			if (s2_valid && s2_uop.acc_wr) begin
				acc <= sat_val;
			end
		end
	end

	// Reserved ops arrive with a zero product and a zero sum
	a_err_zero: assert property (@(posedge clk) disable iff (multAddRst)
		exe_valid && exe_res.err |-> exe_res.value == '0)
		else $error("error result with nonzero value");

endmodule

`default_nettype wire

// ==== src/mac_pkg.sv ====
`default_nettype none

package mac_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Q8.8 operands and results
	localparam int DATA_W = 16;
	localparam int FRAC_W = 8;
	localparam int TAG_W = 4;

	// Scaled product keeps the upper bits of the full product
	localparam int PROD_W = 2 * DATA_W - FRAC_W;
	// One guard bit for the add
	localparam int TOTAL_W = PROD_W + 1;

	// Saturation limits
	localparam int DATA_MAX = (2 ** (DATA_W - 1)) - 1;
	localparam int DATA_MIN = -(2 ** (DATA_W - 1));

	////////////////////////////////////////
	// Depths and credits
	////////////////////////////////////////

	// Command FIFO, also the sender's starting credits
	localparam int CMD_DEPTH = 4;
	// Result FIFO, also the internal issue credits
	localparam int RES_BUF_DEPTH = 4;
	// Downstream credits held after reset
	localparam int RES_CREDITS = 2;

	localparam int ISSUE_CNT_W = $clog2(RES_BUF_DEPTH + 1);
	localparam int RES_CNT_W = $clog2(RES_CREDITS + 1);

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_MAC_EXT  = 2'd0,
		OP_MAC_ACC  = 2'd1,
		OP_ACC_LOAD = 2'd2,
		OP_RSVD     = 2'd3
	} mac_op_e;

	// Incoming command
	typedef struct packed {
		mac_op_e                  op;
		logic [TAG_W-1:0]         tag;
		logic signed [DATA_W-1:0] data;
		logic signed [DATA_W-1:0] weight;
		logic signed [DATA_W-1:0] sum;
	} mac_cmd_t;

	// Decoded operation
	typedef struct packed {
		logic [TAG_W-1:0]         tag;
		logic signed [DATA_W-1:0] data;
		logic signed [DATA_W-1:0] weight;
		logic signed [DATA_W-1:0] sum;
		logic                     use_acc;
		logic                     zero_prod;
		logic                     acc_wr;
		logic                     err;
	} mac_uop_t;

	// Outgoing result
	typedef struct packed {
		logic [TAG_W-1:0]         tag;
		logic signed [DATA_W-1:0] value;
		logic                     err;
	} mac_res_t;

endpackage

`default_nettype wire

// ==== src/mac_result.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_result (
	input logic clk,
	input logic multAddRst,
	input logic exe_valid,
	input mac_pkg::mac_res_t exe_res,
	output logic res_valid,
	output mac_pkg::mac_res_t res,
	input logic res_credit,
	output logic slot_free
);

	import mac_pkg::*;

	mac_res_t head;
	logic res_empty;
	logic send;

	// Receiver slots still available
	logic [RES_CNT_W-1:0] credit_cnt;

	////////////////////////////////////////
	// Result buffer
	////////////////////////////////////////

	// Decode holds a slot for every op in flight
	credit_fifo #(
		.T(mac_res_t),
		.DEPTH(RES_BUF_DEPTH)
	) i_res_fifo (
		.clk(clk),
		.multAddRst(multAddRst),
		.push(exe_valid),
		.push_data(exe_res),
		.pop(send),
		.pop_data(head),
		.empty(res_empty),
		.full()
	);

	assign send = !res_empty && (credit_cnt != '0);

	always_ff @(posedge clk) begin
		if (send) begin
			res <= head;
		end
	end

	always_ff @(posedge clk or posedge multAddRst) begin
		if (multAddRst) begin
			res_valid <= 1'b0;
			slot_free <= 1'b0;
			credit_cnt <= RES_CNT_W'(RES_CREDITS);
		end else begin
			res_valid <= send;
			// Hands the slot back to decode
			slot_free <= send;
			if (send && !res_credit) begin
				credit_cnt <= credit_cnt - 1'b1;
			end else if (res_credit && !send) begin
				credit_cnt <= credit_cnt + 1'b1;
			end
		end
	end

	// Receiver never returns more credits than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (multAddRst)
		credit_cnt <= RES_CNT_W'(RES_CREDITS))
		else $error("downstream credit count above its start value");

endmodule

`default_nettype wire

// ==== src/mac_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_unit (
	input logic clk,
	input logic multAddRst,
	// Command channel
	input logic cmd_valid,
	input mac_pkg::mac_cmd_t cmd,
	output logic cmd_credit,
	// Result channel
	output logic res_valid,
	output mac_pkg::mac_res_t res,
	input logic res_credit
);

	import mac_pkg::*;

	// Decode to execute
	logic uop_valid;
	mac_uop_t uop;

	// Execute to result
	logic exe_valid;
	mac_res_t exe_res;

	// Issue credit return
	logic slot_free;

	mac_decode i_mac_decode (
		.clk(clk),
		.multAddRst(multAddRst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_credit(cmd_credit),
		.slot_free(slot_free),
		.uop_valid(uop_valid),
		.uop(uop)
	);

	// Three cycles, no back-pressure
	mac_execute i_mac_execute (
		.clk(clk),
		.multAddRst(multAddRst),
		.uop_valid(uop_valid),
		.uop(uop),
		.exe_valid(exe_valid),
		.exe_res(exe_res)
	);

	mac_result i_mac_result (
		.clk(clk),
		.multAddRst(multAddRst),
		.exe_valid(exe_valid),
		.exe_res(exe_res),
		.res_valid(res_valid),
		.res(res),
		.res_credit(res_credit),
		.slot_free(slot_free)
	);

endmodule

`default_nettype wire

// ==== tb/mac_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_unit_tb;

	import mac_pkg::*;

	localparam int HALF_PERIOD = 50;
	localparam int DRIVE_DLY = 1;
	localparam int TIMEOUT = 200;
	localparam logic [31:0] SEED = 32'h4276_aec1;

	logic clk = 1'b0;
	logic multAddRst;
	logic cmd_valid;
	mac_cmd_t cmd;
	logic cmd_credit;
	logic res_valid;
	mac_res_t res;
	logic res_credit;

	// Expected results in command order
	mac_res_t exp_q[$];
	int model_acc;
	int cmd_credits;
	// Bench view of the DUT's downstream credits
	int res_credits;
	int owed;
	int credit_wait;
	int rx_count;
	int sent_count;
	logic hold_credits;
	logic rand_delay;
	logic [TAG_W-1:0] next_tag;
	logic [31:0] op_lfsr;
	logic [31:0] dly_lfsr;

	mac_unit i_mac_unit (
		.clk(clk),
		.multAddRst(multAddRst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_credit(cmd_credit),
		.res_valid(res_valid),
		.res(res),
		.res_credit(res_credit)
	);

	always #HALF_PERIOD clk = ~clk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_res(input mac_res_t got, input mac_res_t exp);
		if (got !== exp) begin
			abort_run($sformatf(
				"FAIL %0t res got tag=%0h value=%h err=%b exp tag=%0h value=%h err=%b",
				$time, got.tag, got.value, got.err, exp.tag, exp.value, exp.err));
		end
	endtask

	task automatic compare_credits(input int got, input int exp, input string name);
		if (got != exp) begin
			abort_run($sformatf("FAIL %0t %s got %0d exp %0d", $time, name, got, exp));
		end
	endtask

	task automatic compare_level(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s got %b exp %b", $time, name, got, exp));
		end
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
		logic [31:0] bits;
		logic lsb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lsb = state[0];
			state = state >> 1;
			if (lsb) begin
				state = state ^ 32'h8020_0003;
			end
			bits = {bits[30:0], lsb};
		end
		return bits;
	endfunction

	// Q8.8 rule: floor-scaled product plus sum, clamped to 16 bits
	function automatic mac_res_t model_step(input mac_cmd_t c);
		mac_res_t r;
		int prod;
		int total;
		prod = (int'($signed(c.data)) * int'($signed(c.weight))) >>> FRAC_W;
		case (c.op)
			OP_MAC_EXT: total = prod + int'($signed(c.sum));
			OP_MAC_ACC: total = prod + model_acc;
			OP_ACC_LOAD: total = int'($signed(c.sum));
			default: total = 0;
		endcase
		if (total > DATA_MAX) begin
			total = DATA_MAX;
		end else if (total < DATA_MIN) begin
			total = DATA_MIN;
		end
		// Reserved op leaves the accumulator alone
		if (c.op == OP_MAC_ACC || c.op == OP_ACC_LOAD) begin
			model_acc = total;
		end
		r.tag = c.tag;
		r.value = DATA_W'(total);
		r.err = (c.op == OP_RSVD);
		return r;
	endfunction

	////////////////////////////////////////
	// Channel processes
	////////////////////////////////////////

	// Outputs sampled mid-cycle
	always @(negedge clk) begin
		if (!multAddRst && cmd_credit) begin
			if (cmd_credits >= CMD_DEPTH) begin
				abort_run("cmd_credit pulsed with no command outstanding");
			end else begin
				cmd_credits++;
			end
		end
		if (!multAddRst && res_valid) begin
			if (res_credits == 0) begin
				abort_run("res_valid raised without a downstream credit");
			end else if (exp_q.size() == 0) begin
				abort_run("result arrived with no command outstanding");
			end else begin
				compare_res(res, exp_q.pop_front());
				res_credits--;
				owed++;
				rx_count++;
			end
		end
	end

	// Credit return, optionally held or delayed
	always @(posedge clk) begin
		#DRIVE_DLY;
		res_credit = 1'b0;
		if (credit_wait > 0) begin
			credit_wait--;
		end else if (owed > 0 && !hold_credits) begin
			res_credit = 1'b1;
			owed--;
			res_credits++;
			if (rand_delay) begin
				credit_wait = int'(take_bits(dly_lfsr, 2));
			end
		end
	end

	task automatic send_cmd(input mac_op_e op, input logic [DATA_W-1:0] data,
		input logic [DATA_W-1:0] weight, input logic [DATA_W-1:0] sum);
		mac_cmd_t c;
		int cycles;
		c.op = op;
		c.tag = next_tag;
		c.data = data;
		c.weight = weight;
		c.sum = sum;
		cycles = 0;
		while (cmd_credits == 0 && cycles < TIMEOUT) begin
			@(posedge clk);
			#DRIVE_DLY;
			cycles++;
		end
		if (cmd_credits == 0) begin
			abort_run("timeout waiting for a command credit");
		end else begin
			exp_q.push_back(model_step(c));
			next_tag++;
			cmd_credits--;
			sent_count++;
			cmd_valid = 1'b1;
			cmd = c;
			@(posedge clk);
			#DRIVE_DLY;
			cmd_valid = 1'b0;
		end
	endtask

	task automatic wait_results(input int n);
		int cycles;
		cycles = 0;
		while (rx_count < n && cycles < TIMEOUT) begin
			@(posedge clk);
			#DRIVE_DLY;
			cycles++;
		end
		if (rx_count < n) begin
			abort_run("timeout waiting for results");
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_reset_idle();
		// Both outputs quiet while nothing is sent
		for (int i = 0; i < 8; i++) begin
			idle_cycles(1);
			compare_level(res_valid, 1'b0, "res_valid");
			compare_level(cmd_credit, 1'b0, "cmd_credit");
		end
		// Full credit window back to back
		for (int i = 0; i < CMD_DEPTH; i++) begin
			send_cmd(OP_MAC_EXT, 16'h0100, DATA_W'(i * 64), 16'h0000);
		end
		wait_results(sent_count);
		compare_credits(cmd_credits, CMD_DEPTH, "cmd_credit count");
	endtask

	task automatic test_mac_ext();
		send_cmd(OP_MAC_EXT, 16'h0180, 16'h0200, 16'h0040);
		// Saturation both ways
		send_cmd(OP_MAC_EXT, 16'h6400, 16'h6400, 16'h0000);
		send_cmd(OP_MAC_EXT, 16'h6400, 16'h9c00, 16'h0000);
		send_cmd(OP_MAC_EXT, 16'h0100, 16'h0100, 16'h7f80);
		// Floor of -0.5 LSB and +0.5 LSB
		send_cmd(OP_MAC_EXT, 16'hffff, 16'h0080, 16'h0000);
		send_cmd(OP_MAC_EXT, 16'h0001, 16'h0080, 16'h0000);
		send_cmd(OP_MAC_EXT, 16'hff80, 16'h0003, 16'h0010);
		wait_results(sent_count);
	endtask

	task automatic test_acc_chain();
		send_cmd(OP_ACC_LOAD, 16'h1234, 16'h5678, 16'h0100);
		send_cmd(OP_MAC_ACC, 16'h0200, 16'h0180, 16'h7fff);
		send_cmd(OP_MAC_ACC, 16'hfe00, 16'h0040, 16'h0000);
		// Drive accumulator into the top rail, then back down
		send_cmd(OP_MAC_ACC, 16'h7000, 16'h0400, 16'h0000);
		send_cmd(OP_MAC_ACC, 16'h0100, 16'h0100, 16'h0000);
		send_cmd(OP_MAC_ACC, 16'h8000, 16'h7fff, 16'h0000);
		send_cmd(OP_MAC_ACC, 16'h8000, 16'h7fff, 16'h0000);
		wait_results(sent_count);
	endtask

	task automatic test_reserved();
		send_cmd(OP_ACC_LOAD, 16'h0000, 16'h0000, 16'h0500);
		send_cmd(OP_RSVD, 16'h0300, 16'h0200, 16'h0700);
		send_cmd(OP_MAC_ACC, 16'h0100, 16'h0100, 16'h0000);
		wait_results(sent_count);
	endtask

	task automatic test_back_pressure();
		int base;
		int cycles;
		cycles = 0;
		// DUT must start with every downstream credit back
		while (owed > 0 && cycles < TIMEOUT) begin
			idle_cycles(1);
			cycles++;
		end
		if (owed > 0) begin
			abort_run("timeout waiting for receiver credits to return");
		end
		base = rx_count;
		hold_credits = 1'b1;
		// Fills receiver credits, result FIFO and command FIFO
		for (int i = 0; i < RES_CREDITS + RES_BUF_DEPTH + CMD_DEPTH; i++) begin
			send_cmd(OP_MAC_EXT, DATA_W'(i * 256), 16'h0080, DATA_W'(i));
		end
		idle_cycles(20);
		compare_credits(rx_count - base, RES_CREDITS, "res_valid count");
		compare_credits(cmd_credits, 0, "cmd_credit count");
		hold_credits = 1'b0;
		wait_results(sent_count);
		compare_credits(cmd_credits, CMD_DEPTH, "cmd_credit count");
	endtask

	task automatic test_random_stream();
		logic [31:0] r;
		mac_op_e op;
		logic [DATA_W-1:0] d;
		logic [DATA_W-1:0] w;
		rand_delay = 1'b1;
		for (int i = 0; i < 40; i++) begin
			r = take_bits(op_lfsr, 2);
			op = mac_op_e'(r[1:0]);
			r = take_bits(op_lfsr, DATA_W);
			d = r[DATA_W-1:0];
			r = take_bits(op_lfsr, DATA_W);
			w = r[DATA_W-1:0];
			r = take_bits(op_lfsr, DATA_W);
			send_cmd(op, d, w, r[DATA_W-1:0]);
		end
		wait_results(sent_count);
		rand_delay = 1'b0;
	endtask

	initial begin
		multAddRst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		res_credit = 1'b0;
		model_acc = 0;
		cmd_credits = CMD_DEPTH;
		res_credits = RES_CREDITS;
		owed = 0;
		credit_wait = 0;
		rx_count = 0;
		sent_count = 0;
		hold_credits = 1'b0;
		rand_delay = 1'b0;
		next_tag = '0;
		op_lfsr = SEED;
		dly_lfsr = SEED;
		repeat (4) @(posedge clk);
		#DRIVE_DLY;
		multAddRst = 1'b0;
		test_reset_idle();
		test_mac_ext();
		test_acc_chain();
		test_reserved();
		test_back_pressure();
		test_random_stream();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
